// ==== Makefile ====
# Verilator build and run for the tia_lite testbench

VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP       := tia_lite_tb
FILELIST  := tia_lite.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@./$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q '\*\*\* TEST FAILED \*\*\*' $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== design/line_timer.sv ====
// line_timer: horizontal beam counter, line start, sync, blank, pixel index, rsync reset
`timescale 1ns/1ns
`default_nettype none

module line_timer (
  input  wire                 CCLK,
  input  wire                 reset,
  input  tia_pkg::reg_write_t wr,
  output tia_pkg::beam_t      beam
);

  logic [7:0] count; // colour clock within line
  logic       rsync; // counter reset strobe
  logic       blank;

  assign rsync = wr.valid && (wr.addr == tia_pkg::RSYNC);

  always_ff @(posedge CCLK) begin
    if (reset)
      count <= 8'd0;
    else if (rsync)
      count <= 8'd0;                       // takes effect on the commit edge
    else if (count == tia_pkg::LINE_CLOCKS - 8'd1)
      count <= 8'd0;                       // wrap at 227
    else
      count <= count + 8'd1;
  end

  assign blank = (count < tia_pkg::HBLANK_CLOCKS);

  always_comb begin
    beam.line_start = (count == 8'd0);
    beam.hsync      = (count >= tia_pkg::HSYNC_START) && (count < tia_pkg::HSYNC_END);
    beam.hblank     = blank;
    // visible index 0..159, held at 0 in blank
    beam.pixel      = blank ? 8'd0 : count - tia_pkg::HBLANK_CLOCKS;
  end

endmodule

`default_nettype wire

// ==== design/pixel_gen.sv ====
// pixel_gen: playfield and ball dots, colour select, registered video, ball-playfield collision
`timescale 1ns/1ns
`default_nettype none

module pixel_gen (
  input  wire                 CCLK,
  input  wire                 reset,
  input  tia_pkg::beam_t      beam,
  input  tia_pkg::pf_regs_t   regs,
  output tia_pkg::video_t     video,
  output logic                cx_blpf
);

  logic       visible;
  logic [7:0] pf_col;    // playfield column 0..39
  logic [7:0] pf_sel;    // bit of regs.pf shown
  logic       dot_pf;
  logic [7:0] bl_width;
  logic [8:0] bl_end;    // one past last ball dot, no wrap
  logic       dot_bl;
  logic [7:0] colour;

  assign visible = !beam.hblank;
  assign pf_col  = {2'b00, beam.pixel[7:2]}; // four dots per bit

  always_comb begin
    if (pf_col < tia_pkg::PF_BITS)
      pf_sel = pf_col;                                            // left half
    else if (regs.reflect)
      pf_sel = tia_pkg::PF_BITS + tia_pkg::PF_BITS - 8'd1 - pf_col; // mirrored
    else
      pf_sel = pf_col - tia_pkg::PF_BITS;                         // repeated
  end

  assign dot_pf = visible && regs.pf[pf_sel[4:0]];

  // ball spans [posbl, posbl + width)
  assign bl_width = 8'd1 << regs.ball_size;
  assign bl_end   = {1'b0, regs.posbl} + {1'b0, bl_width};

  assign dot_bl = visible && regs.enabl
               && (beam.pixel >= regs.posbl)
               && ({1'b0, beam.pixel} < bl_end);

  assign colour = (dot_pf || dot_bl) ? regs.colupf : regs.colubk;

  // video lags the beam by one clock
  always_ff @(posedge CCLK) begin
    if (reset) begin
      video.hsync  <= 1'b0;
      video.vsync  <= 1'b0;
      video.vblank <= 1'b0;
      video.lum    <= 3'b000;
      video.col    <= 4'h0;
    end else begin
      video.hsync  <= beam.hsync;
      video.vsync  <= regs.vsync;
      video.vblank <= regs.vblank;
      video.lum    <= beam.hblank ? 3'b000 : colour[3:1]; // bit 0 unused
      video.col    <= beam.hblank ? 4'h0 : colour[7:4];
    end
  end

  // blank one clock behind the beam
  always_ff @(posedge CCLK) begin
    video.hblank <= beam.hblank;
  end

  // sticky until cxclr
  always_ff @(posedge CCLK) begin
    if (reset)
      cx_blpf <= 1'b0;
    else if (regs.cxclr)
      cx_blpf <= 1'b0;
    else if (dot_pf && dot_bl)
      cx_blpf <= 1'b1;
  end

endmodule

`default_nettype wire

// ==== design/tia_bus_fsm.sv ====
// tia_bus_fsm: wishbone classic slave FSM, write decode, wsync stall, read-back mux
`timescale 1ns/1ns
`default_nettype none

module tia_bus_fsm (
  input  wire                 CCLK,
  input  wire                 reset,
  input  tia_pkg::wb_req_t    bus_req,
  input  tia_pkg::beam_t      beam,
  input  wire                 cx_blpf,
  output logic                bus_ack,
  output logic [7:0]          bus_dat_r,
  output tia_pkg::reg_write_t wr
);

  tia_pkg::bus_state_e state, state_nxt;
  tia_pkg::reg_addr_e  addr;   // decoded address
  logic                commit; // request seen in idle

  assign addr   = tia_pkg::reg_addr_e'(bus_req.adr);
  assign commit = (state == tia_pkg::IDLE) && bus_req.cyc && bus_req.stb;

  // write pulse lands in the registers on the commit edge
  always_comb begin
    wr.valid = commit && bus_req.we;
    wr.addr  = addr;
    wr.data  = bus_req.dat;
  end

  always_comb begin
    state_nxt = state;
    case (state)
      tia_pkg::IDLE: begin
        if (commit) begin
          if (bus_req.we && addr == tia_pkg::WSYNC)
            state_nxt = tia_pkg::WAIT_LINE; // hold ack until next line
          else
            state_nxt = tia_pkg::ACK;
        end
      end
      tia_pkg::WAIT_LINE: begin
        if (beam.line_start)
          state_nxt = tia_pkg::ACK;
      end
      tia_pkg::ACK: state_nxt = tia_pkg::IDLE; // single ack cycle
      default: state_nxt = tia_pkg::IDLE;
    endcase
  end

  always_ff @(posedge CCLK) begin
    if (reset)
      state <= tia_pkg::IDLE;
    else
      state <= state_nxt;
  end

  // read data captured at commit, held through ack
  always_ff @(posedge CCLK) begin
    if (reset)
      bus_dat_r <= 8'h00;
    else if (commit && !bus_req.we)
      bus_dat_r <= (addr == tia_pkg::CXBLPF) ? {cx_blpf, 7'b0000000} : 8'h00;
  end

  assign bus_ack = (state == tia_pkg::ACK);

endmodule

`default_nettype wire

// ==== design/tia_lite.sv ====
// tia_lite: top level wiring of bus FSM, line timer, register file and pixel generator
`timescale 1ns/1ns
`default_nettype none

module tia_lite (
  input  wire              CCLK,
  input  wire              reset,
  input  tia_pkg::wb_req_t bus_req,
  output logic             bus_ack,
  output logic [7:0]       bus_dat_r,
  output tia_pkg::video_t  video
);

  tia_pkg::reg_write_t wr;      // decoded write pulse
  tia_pkg::beam_t      beam;
  tia_pkg::pf_regs_t   regs;
  logic                cx_blpf; // ball-playfield latch

  tia_bus_fsm u_bus (
    .CCLK      (CCLK),
    .reset     (reset),
    .bus_req   (bus_req),
    .beam      (beam),
    .cx_blpf   (cx_blpf),
    .bus_ack   (bus_ack),
    .bus_dat_r (bus_dat_r),
    .wr        (wr)
  );

  line_timer u_timer (
    .CCLK  (CCLK),
    .reset (reset),
    .wr    (wr),     // rsync only
    .beam  (beam)
  );

  tia_registers u_regs (
    .CCLK  (CCLK),
    .reset (reset),
    .wr    (wr),
    .beam  (beam),   // for resbl capture
    .regs  (regs)
  );

  pixel_gen u_pix (
    .CCLK    (CCLK),
    .reset   (reset),
    .beam    (beam),
    .regs    (regs),
    .video   (video),
    .cx_blpf (cx_blpf)
  );

endmodule

`default_nettype wire

// ==== design/tia_pkg.sv ====
// tia_lite shared timing constants, bus address and state enums, packed structs
`default_nettype none

package tia_pkg;

  // horizontal timing, in colour clocks
  localparam logic [7:0] LINE_CLOCKS    = 8'd228; // full scan line
  localparam logic [7:0] HBLANK_CLOCKS  = 8'd68;  // blank at line start
  localparam logic [7:0] HSYNC_START    = 8'd20;
  localparam logic [7:0] HSYNC_END      = 8'd36;  // first count after sync
  localparam logic [7:0] VISIBLE_PIXELS = 8'd160;
  localparam logic [7:0] PF_BITS        = 8'd20;  // one playfield half
  localparam logic [7:0] RESBL_OFFSET   = 8'd2;   // ball strobe during blank

  // bus addresses, write strobes plus the one collision read
  typedef enum logic [5:0] {
    VSYNC  = 6'h00,
    VBLANK = 6'h01,
    WSYNC  = 6'h02,
    RSYNC  = 6'h03,
    CXBLPF = 6'h06, // read only
    COLUPF = 6'h08,
    COLUBK = 6'h09,
    CTRLPF = 6'h0A,
    PF0    = 6'h0D,
    PF1    = 6'h0E,
    PF2    = 6'h0F,
    RESBL  = 6'h14,
    ENABL  = 6'h1F,
    CXCLR  = 6'h2C
  } reg_addr_e;

  typedef enum logic [1:0] {
    IDLE,
    ACK,
    WAIT_LINE // wsync stall
  } bus_state_e;

  // wishbone classic master request
  typedef struct packed {
    logic       cyc;
    logic       stb;
    logic       we;
    logic [5:0] adr;
    logic [7:0] dat;
  } wb_req_t;

  // one decoded register write
  typedef struct packed {
    logic       valid;
    reg_addr_e  addr;
    logic [7:0] data;
  } reg_write_t;

  typedef struct packed {
    logic       line_start; // count 0
    logic       hsync;
    logic       hblank;
    logic [7:0] pixel;      // 0 during blank
  } beam_t;

  typedef struct packed {
    logic        vsync;
    logic        vblank;
    logic [19:0] pf;        // bit 0 is leftmost dot
    logic [7:0]  colupf;
    logic [7:0]  colubk;
    logic        reflect;
    logic [1:0]  ball_size;
    logic [7:0]  posbl;
    logic        enabl;
    logic        cxclr;     // one-cycle pulse
  } pf_regs_t;

  typedef struct packed {
    logic       hsync;
    logic       hblank;
    logic       vsync;
    logic       vblank;
    logic [2:0] lum;
    logic [3:0] col;
  } video_t;

endpackage

`default_nettype wire

// ==== design/tia_registers.sv ====
// tia_registers: video control register file, playfield assembly, ball position strobe
`timescale 1ns/1ns
`default_nettype none

module tia_registers (
  input  wire                 CCLK,
  input  wire                 reset,
  input  tia_pkg::reg_write_t wr,
  input  tia_pkg::beam_t      beam,
  output tia_pkg::pf_regs_t   regs
);

  logic       vsync;
  logic       vblank;
  logic [3:0] pf0;       // only bits 7..4 of the write
  logic [7:0] pf1;
  logic [7:0] pf2;
  logic [7:0] colupf;
  logic [7:0] colubk;
  logic       reflect;
  logic [1:0] ball_size;
  logic [7:0] posbl;
  logic       enabl;
  logic       cxclr;

  always_ff @(posedge CCLK) begin
    if (reset) begin
      vsync     <= 1'b0;
      vblank    <= 1'b0;
      pf0       <= 4'h0;
      pf1       <= 8'h00;
      pf2       <= 8'h00;
      colupf    <= 8'h00;
      colubk    <= 8'h00;
      reflect   <= 1'b0;
      ball_size <= 2'b00;
      posbl     <= 8'h00;
      enabl     <= 1'b0;
    end else if (wr.valid) begin
      case (wr.addr)
        tia_pkg::VSYNC:  vsync  <= wr.data[1];
        tia_pkg::VBLANK: vblank <= wr.data[1];
        tia_pkg::COLUPF: colupf <= wr.data;
        tia_pkg::COLUBK: colubk <= wr.data;
        tia_pkg::CTRLPF: begin
          reflect   <= wr.data[0];
          ball_size <= wr.data[5:4]; // 1, 2, 4 or 8 dots
        end
        tia_pkg::PF0: pf0 <= wr.data[7:4];
        tia_pkg::PF1: pf1 <= wr.data;
        tia_pkg::PF2: pf2 <= wr.data;
        tia_pkg::RESBL: begin
          // strobe during blank parks the ball just right of the left edge
          if (beam.hblank)
            posbl <= beam.pixel + tia_pkg::RESBL_OFFSET;
          else
            posbl <= beam.pixel;
        end
        tia_pkg::ENABL: enabl <= wr.data[1];
        default: ;
      endcase
    end
  end

  // collision clear pulse, one cycle after the write
  always_ff @(posedge CCLK) begin
    if (reset)
      cxclr <= 1'b0;
    else
      cxclr <= wr.valid && (wr.addr == tia_pkg::CXCLR);
  end

  always_comb begin
    regs.vsync     = vsync;
    regs.vblank    = vblank;
    // display order: pf0 4..7, pf1 7..0, pf2 0..7
    regs.pf        = {pf2,
                      pf1[0], pf1[1], pf1[2], pf1[3], pf1[4], pf1[5], pf1[6], pf1[7],
                      pf0};
    regs.colupf    = colupf;
    regs.colubk    = colubk;
    regs.reflect   = reflect;
    regs.ball_size = ball_size;
    regs.posbl     = posbl;
    regs.enabl     = enabl;
    regs.cxclr     = cxclr;
  end

endmodule

`default_nettype wire

// ==== tia_lite.f ====
design/tia_pkg.sv
design/tia_bus_fsm.sv
design/line_timer.sv
design/tia_registers.sv
design/pixel_gen.sv
design/tia_lite.sv
verification/tia_lite_properties.sv
verification/tia_lite_tb.sv

// ==== verification/tia_lite_properties.sv ====
// tia_lite_properties: wishbone ack assertions, bound into tia_bus_fsm
`timescale 1ns/1ns
`default_nettype none

module tia_lite_properties (
  input wire              CCLK,
  input wire              reset,
  input tia_pkg::wb_req_t bus_req,
  input wire              bus_ack
);

  int fail_count = 0; // failed assertions, read by the testbench

  // ack is a single-cycle pulse
  ack_single: assert property (@(posedge CCLK) disable iff (reset) bus_ack |=> !bus_ack)
    else begin
      fail_count++;
      $error("bus_ack high for two cycles in a row");
    end

  // no ack without a live request
  ack_needs_req: assert property (@(posedge CCLK) disable iff (reset)
    bus_ack |-> (bus_req.cyc && bus_req.stb))
    else begin
      fail_count++;
      $error("bus_ack high while cyc or stb is low");
    end

  ack_after_reset: assert property (@(posedge CCLK) reset |=> !bus_ack)
    else begin
      fail_count++;
      $error("bus_ack high in the cycle after reset");
    end

endmodule

bind tia_bus_fsm tia_lite_properties u_props (
  .CCLK    (CCLK),
  .reset   (reset),
  .bus_req (bus_req),
  .bus_ack (bus_ack)
);

`default_nettype wire

// ==== verification/tia_lite_tb.sv ====
// tia_lite_tb: clock, reset, bus tasks, reference dot count, checks, watchdog, summary
`timescale 1ns/1ns
`default_nettype none

module tia_lite_tb;

  localparam int LINE        = 228; // clocks per line
  localparam int VISIBLE     = 160;
  localparam int NUM_TESTS   = 6;
  localparam int ACK_LIMIT   = 300; // longest wsync stall is 228
  localparam int WDOG_CYCLES = NUM_TESTS * 6 * LINE + 500;

  logic                CCLK;
  logic                reset;
  tia_pkg::wb_req_t    bus_req;
  logic                bus_ack;
  logic [7:0]          bus_dat_r;
  tia_pkg::video_t     video;

  int cycle_no  = 0;
  int ack_cycle = 0; // cycle number of the edge that raised the last ack
  int err_count = 0;
  int tests_ok  = 0;
  int tests_bad = 0;

  tia_lite u_dut (
    .CCLK      (CCLK),
    .reset     (reset),
    .bus_req   (bus_req),
    .bus_ack   (bus_ack),
    .bus_dat_r (bus_dat_r),
    .video     (video)
  );

  initial begin
    CCLK = 1'b0;
    forever #20 CCLK = ~CCLK; // 40 ns period
  end

  always @(posedge CCLK) cycle_no <= cycle_no + 1;

  // expected colupf cycles in one visible line
  function automatic int colupf_dots(input logic [7:0] pf0, input logic [7:0] pf1,
                                     input logic [7:0] pf2, input logic reflect,
                                     input logic ball_en, input int ball_width,
                                     input int ball_pos);
    logic [19:0] order; // index 0 is leftmost
    int          i;
    int          p;
    int          col;
    int          n;
    logic        dot;
    for (i = 0; i < 4; i++) order[i] = pf0[4 + i];
    for (i = 0; i < 8; i++) order[4 + i] = pf1[7 - i]; // pf1 shown msb first
    for (i = 0; i < 8; i++) order[12 + i] = pf2[i];
    n = 0;
    for (p = 0; p < VISIBLE; p++) begin
      col = p / 4;
      if (col < 20)
        dot = order[col];
      else if (reflect)
        dot = order[39 - col]; // mirrored right half
      else
        dot = order[col - 20];
      if (ball_en && p >= ball_pos && p < ball_pos + ball_width)
        dot = 1'b1;
      if (dot)
        n++;
    end
    return n;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
    err_count++;
  endtask

  task automatic report_error(input string what);
    $display("error: %s", what);
    err_count++;
  endtask

  task automatic finish_test(input string name, input int errs_before);
    if (err_count == errs_before) begin
      $display("test %s: ok", name);
      tests_ok++;
    end else begin
      $display("test %s: %0d errors", name, err_count - errs_before);
      tests_bad++;
    end
  endtask

  // always entered and left 1 ns after a rising edge
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge CCLK);
    #1;
  endtask

  task automatic bus_cycle(input logic we, input logic [5:0] adr, input logic [7:0] dat,
                           output logic [7:0] rdata, output int latency);
    int n;
    bus_req.cyc = 1'b1;
    bus_req.stb = 1'b1;
    bus_req.we  = we;
    bus_req.adr = adr;
    bus_req.dat = dat;
    rdata   = 8'h00;
    latency = -1;
    n       = 0;
    while (latency < 0 && n < ACK_LIMIT) begin
      @(posedge CCLK);
      #1;
      n++;
      if (bus_ack) begin
        latency   = n - 1; // cycles from commit edge to ack
        ack_cycle = cycle_no;
        rdata     = bus_dat_r;
      end
    end
    if (latency < 0)
      report_error($sformatf("no bus_ack within %0d cycles at address 0x%0h", ACK_LIMIT, adr));
    @(posedge CCLK); // hold through the ack cycle
    #1;
    bus_req.cyc = 1'b0;
    bus_req.stb = 1'b0;
    bus_req.we  = 1'b0;
  endtask

  task automatic write_reg(input logic [5:0] adr, input logic [7:0] dat);
    logic [7:0] unused_rd;
    int         lat;
    bus_cycle(1'b1, adr, dat, unused_rd, lat);
  endtask

  task automatic read_reg(input logic [5:0] adr, output logic [7:0] rd);
    int lat;
    bus_cycle(1'b0, adr, 8'h00, rd, lat);
  endtask

  task automatic wsync(output int lat);
    logic [7:0] unused_rd;
    bus_cycle(1'b1, tia_pkg::WSYNC, 8'h00, unused_rd, lat);
  endtask

  // one full line of video, colour hits and strays
  task automatic sample_line(input logic [7:0] cpf, input logic [7:0] cbk,
                             output int hits, output int vis, output int stray);
    int i;
    hits  = 0;
    vis   = 0;
    stray = 0;
    for (i = 0; i < LINE; i++) begin
      @(posedge CCLK);
      #1;
      if (!video.hblank) begin
        vis++;
        if ({video.col, video.lum} == cpf[7:1])
          hits++;
        else if ({video.col, video.lum} != cbk[7:1])
          stray++;
      end
    end
  endtask

  task automatic check_line_timing();
    int   t;
    int   t_hb;
    int   t_hs1;
    int   t_hs2;
    int   hs_high;
    int   hb_high;
    logic prev_hs;
    logic prev_hb;
    t_hb    = -1;
    t_hs1   = -1;
    t_hs2   = -1;
    hs_high = 0;
    hb_high = 0;
    prev_hs = video.hsync;
    prev_hb = video.hblank;
    for (t = 0; t < 4 * LINE && t_hs2 < 0; t++) begin
      @(posedge CCLK);
      #1;
      if (t_hb < 0) begin
        if (video.hblank && !prev_hb) t_hb = t;
      end else if (t_hs1 < 0) begin
        if (video.hsync && !prev_hs) t_hs1 = t; // first sync after blank rise
      end else if (video.hsync && !prev_hs) begin
        t_hs2 = t;
      end
      if (t_hs1 >= 0 && t_hs2 < 0) begin
        if (video.hsync) hs_high++;
        if (video.hblank) hb_high++;
      end
      prev_hs = video.hsync;
      prev_hb = video.hblank;
    end
    if (t_hs2 < 0) begin
      report_error("two hsync rises not seen within four lines");
    end else begin
      if (t_hs2 - t_hs1 != LINE) report_mismatch("video.hsync period", t_hs2 - t_hs1, LINE);
      if (t_hs1 - t_hb != 20) report_mismatch("video.hsync after hblank", t_hs1 - t_hb, 20);
      if (hs_high != 16) report_mismatch("video.hsync width", hs_high, 16);
      if (hb_high != 68) report_mismatch("video.hblank width", hb_high, 68);
    end
  endtask

  // the checking process, one block per behavior
  initial begin : run_checks
    logic [7:0] pf0;
    logic [7:0] pf1;
    logic [7:0] pf2;
    logic [7:0] cpf;
    logic [7:0] cbk;
    logic [7:0] d0;
    logic [7:0] d1;
    logic [7:0] rd;
    logic       refl;
    logic [1:0] size;
    logic       prev_hs;
    int         errs;
    int         lat;
    int         hits;
    int         vis;
    int         stray;
    int         expect_n;
    int         rise;
    int         i;
    bus_req = '0;
    reset   = 1'b1;
    void'($urandom(32'h359f));
    repeat (8) @(posedge CCLK);
    #1 reset = 1'b0;

    errs = err_count;
    check_line_timing();
    finish_test("line timing", errs);

    errs = err_count;
    d0 = 8'($urandom);
    d1 = 8'($urandom);
    write_reg(tia_pkg::VSYNC, d0);
    write_reg(tia_pkg::VBLANK, d1);
    if (video.vsync !== d0[1]) report_mismatch("video.vsync", video.vsync, d0[1]);
    if (video.vblank !== d1[1]) report_mismatch("video.vblank", video.vblank, d1[1]);
    read_reg(6'h05, rd); // nothing mapped there
    if (rd !== 8'h00) report_mismatch("bus_dat_r", rd, 8'h00);
    finish_test("vertical signals", errs);

    errs = err_count;
    pf0  = 8'($urandom);
    pf1  = 8'($urandom);
    pf2  = 8'($urandom);
    refl = 1'($urandom);
    cpf  = 8'($urandom);
    cbk  = 8'($urandom);
    while (cbk[7:1] == cpf[7:1]) cbk = 8'($urandom); // bit 0 not displayed
    write_reg(tia_pkg::PF0, pf0);
    write_reg(tia_pkg::PF1, pf1);
    write_reg(tia_pkg::PF2, pf2);
    write_reg(tia_pkg::CTRLPF, {7'b0000000, refl});
    write_reg(tia_pkg::COLUPF, cpf);
    write_reg(tia_pkg::COLUBK, cbk);
    write_reg(tia_pkg::ENABL, 8'h00);
    wsync(lat);
    sample_line(cpf, cbk, hits, vis, stray);
    expect_n = colupf_dots(pf0, pf1, pf2, refl, 1'b0, 1, 0);
    if (hits != expect_n) report_mismatch("video colupf count", hits, expect_n);
    if (vis != VISIBLE) report_mismatch("video visible count", vis, VISIBLE);
    if (stray != 0)
      report_error($sformatf("%0d visible cycles showed neither colour", stray));
    finish_test("playfield", errs);

    errs = err_count;
    wait_cycles($urandom_range(LINE - 1, 0)); // random line phase
    wsync(lat);
    if (lat < 1 || lat > LINE) report_mismatch("bus_ack wsync latency", lat, LINE);
    if (video.hblank !== 1'b1) report_mismatch("video.hblank", video.hblank, 1'b1);
    finish_test("wsync stall", errs);

    errs = err_count;
    write_reg(tia_pkg::PF0, 8'h00);
    write_reg(tia_pkg::PF1, 8'h00);
    write_reg(tia_pkg::PF2, 8'h00);
    wsync(lat);
    write_reg(tia_pkg::RESBL, 8'($urandom)); // strobe in blank, ball at 2
    write_reg(tia_pkg::ENABL, 8'($urandom) | 8'h02);
    size = 2'($urandom);
    write_reg(tia_pkg::CTRLPF, {2'b00, size, 4'b0000});
    sample_line(cpf, cbk, hits, vis, stray);
    expect_n = colupf_dots(8'h00, 8'h00, 8'h00, 1'b0, 1'b1, 1 << size, 2);
    if (hits != expect_n) report_mismatch("video ball width", hits, expect_n);
    read_reg(tia_pkg::CXBLPF, rd);
    if (rd !== 8'h00) report_mismatch("bus_dat_r CXBLPF", rd, 8'h00);
    write_reg(tia_pkg::PF0, 8'hF0);
    write_reg(tia_pkg::PF1, 8'hFF);
    write_reg(tia_pkg::PF2, 8'hFF);
    wait_cycles(LINE); // let a visible stretch overlap
    read_reg(tia_pkg::CXBLPF, rd);
    if (rd !== 8'h80) report_mismatch("bus_dat_r CXBLPF", rd, 8'h80);
    read_reg(6'h05, rd); // unmapped read while the latch is set
    if (rd !== 8'h00) report_mismatch("bus_dat_r", rd, 8'h00);
    write_reg(tia_pkg::PF0, 8'h00);
    write_reg(tia_pkg::PF1, 8'h00);
    write_reg(tia_pkg::PF2, 8'h00);
    write_reg(tia_pkg::CXCLR, 8'h00);
    read_reg(tia_pkg::CXBLPF, rd);
    if (rd !== 8'h00) report_mismatch("bus_dat_r CXBLPF", rd, 8'h00);
    finish_test("ball and collision", errs);

    errs = err_count;
    wait_cycles($urandom_range(LINE - 1, 0));
    write_reg(tia_pkg::RSYNC, 8'($urandom));
    rise    = -1;
    prev_hs = video.hsync;
    for (i = 0; i < 2 * LINE && rise < 0; i++) begin
      @(posedge CCLK);
      #1;
      if (video.hsync && !prev_hs) rise = cycle_no;
      prev_hs = video.hsync;
    end
    // count zeroed on the commit edge, sync from count 20, video one clock later
    if (rise < 0)
      report_error("no hsync rise within two lines of the RSYNC write");
    else if (rise - ack_cycle != 21)
      report_mismatch("video.hsync after RSYNC commit", rise - ack_cycle, 21);
    finish_test("rsync", errs);

    $display("summary: %0d tests ok, %0d tests with errors, %0d failed checks, %0d failed asserts",
             tests_ok, tests_bad, err_count, u_dut.u_bus.u_props.fail_count);
    if (err_count == 0 && u_dut.u_bus.u_props.fail_count == 0 && tests_ok == NUM_TESTS)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin : watchdog
    repeat (WDOG_CYCLES) @(posedge CCLK);
    $display("error: run still going after %0d cycles", WDOG_CYCLES);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire
